// File: source/pv_hash_pkg.sv
// Shared sizes for the PCR hash generator
// Message padding constants and fold core parameters

package pv_hash_pkg;

  // Dword width used by the PCR store, the sequencer and the core
  localparam int PV_DATA_W = 32;

  // PCR store geometry
  localparam int PV_NUM_PCR = 8;
  localparam int PV_NUM_DWORDS = 4;
  localparam int PV_ENTRY_ADDR_W = 3;
  localparam int PV_ENTRY_SIZE_WIDTH = 2;

  // The nonce is appended after the last PCR dword
  localparam int PV_SIZE_OF_NONCE = 32;

  // The block buffer of the hashing core holds one dword per slot
  localparam int BLOCK_NO = 32;
  localparam int BLOCK_OFFSET_W = 5;

  // The 128-bit length field takes the last four dwords of the final block
  localparam int PAD_LEN_DWORD = BLOCK_NO - 4;

  // Message length in bits covers all PCR dwords and the nonce
  localparam logic [4*PV_DATA_W-1:0] PAD_LENGTH =
    128'(PV_NUM_PCR * PV_NUM_DWORDS * PV_DATA_W + PV_SIZE_OF_NONCE);

  // Starting digest for an init block
  localparam logic [PV_DATA_W-1:0] FOLD_IV = 32'h6a09_e667;

  // Left rotate applied to the digest before each word is added
  localparam int FOLD_ROT = 5;

endpackage

// File: source/pcr_store.sv
// PCR register file with 8 entries of 4 dwords
// One synchronous write port and one combinational read port

`timescale 1ns/1ps

module pcr_store
  import pv_hash_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_b,

  // Write port
  input  logic                           we_i,
  input  logic [PV_ENTRY_ADDR_W-1:0]     wr_entry_i,
  input  logic [PV_ENTRY_SIZE_WIDTH-1:0] wr_offset_i,
  input  logic [PV_DATA_W-1:0]           wr_data_i,

  // Read data is valid in the same cycle as the address
  input  logic [PV_ENTRY_ADDR_W-1:0]     rd_entry_i,
  input  logic [PV_ENTRY_SIZE_WIDTH-1:0] rd_offset_i,
  output logic [PV_DATA_W-1:0]           rd_data_o
);

  logic [PV_DATA_W-1:0] pcr_mem [PV_NUM_PCR][PV_NUM_DWORDS];

  // PCR values start from zero after reset
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      for (int e = 0; e < PV_NUM_PCR; e++) begin
        for (int d = 0; d < PV_NUM_DWORDS; d++) begin
          pcr_mem[e][d] <= '0;
        end
      end
    end else if (we_i) begin
      pcr_mem[wr_entry_i][wr_offset_i] <= wr_data_i;
    end
  end

  // The sequencer writes this dword straight into the block buffer
  assign rd_data_o = pcr_mem[rd_entry_i][rd_offset_i];

endmodule

// File: source/pv_gen_hash.sv
// Hash sequencer FSM
// Streams the PCR dwords, the nonce and the message padding into the core block buffer
// and issues the init, next and last strobes

`timescale 1ns/1ps

module pv_gen_hash
  import pv_hash_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_b,

  input  logic                           start_i,
  input  logic                           core_ready_i,
  input  logic                           core_digest_valid_i,
  input  logic [PV_SIZE_OF_NONCE-1:0]    nonce_i,
  input  logic [PV_DATA_W-1:0]           rd_data_i,

  output logic                           gen_hash_ip_o,
  output logic                           init_o,
  output logic                           next_o,
  output logic                           last_o,

  output logic                           block_we_o,
  output logic [BLOCK_OFFSET_W-1:0]      block_offset_o,
  output logic [PV_DATA_W-1:0]           block_wr_data_o,

  output logic [PV_ENTRY_ADDR_W-1:0]     rd_entry_o,
  output logic [PV_ENTRY_SIZE_WIDTH-1:0] rd_offset_o
);

  typedef enum logic [3:0] {
    ST_IDLE    = 4'b0000,
    ST_BLOCK_0 = 4'b0001,
    ST_BLOCK_N = 4'b0011,
    ST_NONCE   = 4'b0010,
    ST_PAD_LD1 = 4'b0110,
    ST_PAD_0S  = 4'b0111,
    ST_PAD_LEN = 4'b0101,
    ST_WT_LAST = 4'b0100,
    ST_DONE    = 4'b1100
  } gen_state_e;

  gen_state_e state_q;
  gen_state_e state_d;

  // One extra bit so that a full buffer shows as offset BLOCK_NO
  logic [BLOCK_OFFSET_W:0] block_offset_q;
  logic [BLOCK_OFFSET_W:0] block_offset_d;
  logic                    block_full;
  logic                    blk_handoff;

  // Set at start and cleared once the first block has gone out as init
  logic init_pend_q;

  logic [PV_ENTRY_ADDR_W-1:0]     rd_entry_q;
  logic [PV_ENTRY_ADDR_W-1:0]     rd_entry_d;
  logic [PV_ENTRY_SIZE_WIDTH-1:0] rd_offset_q;
  logic [PV_ENTRY_SIZE_WIDTH-1:0] rd_offset_d;
  logic                           inc_rd_ptr;
  logic                           rst_rd_ptr;
  logic                           entry_wrap;
  logic                           last_dword_rd;

  logic [3:0][PV_DATA_W-1:0] pad_length;

  logic arc_idle_blk0;
  logic arc_blk0_blkn;
  logic arc_blkn_blkn;
  logic arc_blk0_nonce;
  logic arc_blkn_nonce;
  logic arc_nonce_ld1;
  logic arc_ld1_zeros;
  logic arc_zeros_len;
  logic arc_len_wtlast;
  logic arc_wtlast_done;

  assign pad_length = PAD_LENGTH;

  assign block_full = (block_offset_q == (BLOCK_OFFSET_W+1)'(BLOCK_NO));

  // A full buffer is handed to the core as soon as it is ready
  assign blk_handoff = block_full & core_ready_i &
                       (state_q inside {ST_BLOCK_0, ST_BLOCK_N, ST_NONCE,
                                        ST_PAD_LD1, ST_PAD_0S, ST_PAD_LEN});

  // State arcs
  assign arc_idle_blk0   = (state_q == ST_IDLE) & start_i;
  assign arc_blk0_blkn   = (state_q == ST_BLOCK_0) & block_full & core_ready_i;
  assign arc_blkn_blkn   = (state_q == ST_BLOCK_N) & block_full & core_ready_i;
  assign arc_blk0_nonce  = (state_q == ST_BLOCK_0) & ~block_full & last_dword_rd;
  assign arc_blkn_nonce  = (state_q == ST_BLOCK_N) & ~block_full & last_dword_rd;
  assign arc_nonce_ld1   = (state_q == ST_NONCE) & ~block_full;
  assign arc_ld1_zeros   = (state_q == ST_PAD_LD1) & ~block_full;
  assign arc_zeros_len   = (state_q == ST_PAD_0S) & ~block_full &
                           (block_offset_q == (BLOCK_OFFSET_W+1)'(PAD_LEN_DWORD-1));
  assign arc_len_wtlast  = (state_q == ST_PAD_LEN) & block_full & core_ready_i;
  assign arc_wtlast_done = (state_q == ST_WT_LAST) & core_digest_valid_i;

  // The first handoff of a run is an init, every later one a next
  assign init_o = blk_handoff & init_pend_q;
  assign next_o = blk_handoff & ~init_pend_q;
  assign last_o = (state_q == ST_WT_LAST);

  assign gen_hash_ip_o = (state_q != ST_IDLE);

  // Writes stop while the buffer is full and waiting for the core
  assign block_we_o = ~(state_q inside {ST_IDLE, ST_WT_LAST, ST_DONE}) & ~block_full;
  assign block_offset_o = block_offset_q[BLOCK_OFFSET_W-1:0];

  always_comb begin
    if (blk_handoff) begin
      block_offset_d = '0;
    end else if (block_we_o) begin
      block_offset_d = block_offset_q + 1'b1;
    end else begin
      block_offset_d = block_offset_q;
    end
  end

  // PCR read pointer walks the dword offset first, then the entry
  assign inc_rd_ptr    = (state_q inside {ST_BLOCK_0, ST_BLOCK_N}) & ~block_full;
  assign rst_rd_ptr    = arc_blk0_nonce | arc_blkn_nonce;
  assign entry_wrap    = (rd_offset_q == PV_ENTRY_SIZE_WIDTH'(PV_NUM_DWORDS-1));
  assign last_dword_rd = entry_wrap & (rd_entry_q == PV_ENTRY_ADDR_W'(PV_NUM_PCR-1));

  always_comb begin
    rd_entry_d  = rd_entry_q;
    rd_offset_d = rd_offset_q;
    if (rst_rd_ptr) begin
      rd_entry_d  = '0;
      rd_offset_d = '0;
    end else if (inc_rd_ptr) begin
      if (entry_wrap) begin
        rd_offset_d = '0;
        rd_entry_d  = rd_entry_q + 1'b1;
      end else begin
        rd_offset_d = rd_offset_q + 1'b1;
      end
    end
  end

  assign rd_entry_o  = rd_entry_q;
  assign rd_offset_o = rd_offset_q;

  // Next state and the dword that goes into the buffer this cycle
  always_comb begin
    state_d         = state_q;
    block_wr_data_o = '0;
    unique case (state_q)
      ST_IDLE: begin
        if (arc_idle_blk0) state_d = ST_BLOCK_0;
      end
      ST_BLOCK_0: begin
        if (arc_blk0_blkn) state_d = ST_BLOCK_N;
        else if (arc_blk0_nonce) state_d = ST_NONCE;
        block_wr_data_o = rd_data_i;
      end
      ST_BLOCK_N: begin
        if (arc_blkn_blkn) state_d = ST_BLOCK_N;
        else if (arc_blkn_nonce) state_d = ST_NONCE;
        block_wr_data_o = rd_data_i;
      end
      ST_NONCE: begin
        if (arc_nonce_ld1) state_d = ST_PAD_LD1;
        block_wr_data_o = nonce_i;
      end
      ST_PAD_LD1: begin
        if (arc_ld1_zeros) state_d = ST_PAD_0S;
        block_wr_data_o = 32'h8000_0000;
      end
      ST_PAD_0S: begin
        if (arc_zeros_len) state_d = ST_PAD_LEN;
      end
      ST_PAD_LEN: begin
        if (arc_len_wtlast) state_d = ST_WT_LAST;
        // Offset 28 takes the most significant length dword
        block_wr_data_o = pad_length[~block_offset_q[1:0]];
      end
      ST_WT_LAST: begin
        if (arc_wtlast_done) state_d = ST_DONE;
      end
      ST_DONE: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q        <= ST_IDLE;
      block_offset_q <= '0;
      init_pend_q    <= 1'b0;
      rd_entry_q     <= '0;
      rd_offset_q    <= '0;
    end else begin
      state_q        <= state_d;
      block_offset_q <= block_offset_d;
      rd_entry_q     <= rd_entry_d;
      rd_offset_q    <= rd_offset_d;
      if (arc_idle_blk0) begin
        init_pend_q <= 1'b1;
      end else if (init_o) begin
        init_pend_q <= 1'b0;
      end
    end
  end

endmodule

// File: source/block_fold_core.sv
// Fold core with a 32-dword write buffer and a working copy
// Folds one word per cycle into a 32-bit digest

`timescale 1ns/1ps

module block_fold_core
  import pv_hash_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_b,

  // Block buffer write port
  input  logic                      block_we_i,
  input  logic [BLOCK_OFFSET_W-1:0] block_offset_i,
  input  logic [PV_DATA_W-1:0]      block_wr_data_i,

  input  logic                      init_i,
  input  logic                      next_i,
  input  logic                      last_i,

  output logic                      ready_o,
  output logic                      digest_valid_o,
  output logic [PV_DATA_W-1:0]      digest_o
);

  logic [PV_DATA_W-1:0] blk_buf  [BLOCK_NO];
  logic [PV_DATA_W-1:0] work_buf [BLOCK_NO];

  logic                      busy_q;
  logic [BLOCK_OFFSET_W-1:0] word_cnt_q;
  logic [PV_DATA_W-1:0]      digest_q;
  logic                      digest_valid_q;

  logic                      blk_start;
  logic                      last_word;
  logic [PV_DATA_W-1:0]      digest_rot;
  logic [PV_DATA_W-1:0]      fold_sum;

  // Strobes are only taken while the engine is idle
  assign blk_start = (init_i | next_i) & ~busy_q;
  assign last_word = (word_cnt_q == BLOCK_OFFSET_W'(BLOCK_NO-1));

  // One fold step rotates left and then adds modulo 2^32
  assign digest_rot = {digest_q[PV_DATA_W-FOLD_ROT-1:0],
                       digest_q[PV_DATA_W-1:PV_DATA_W-FOLD_ROT]};
  assign fold_sum   = digest_rot + work_buf[word_cnt_q];

  // The working copy lets the sequencer refill the buffer during a fold
  always_ff @(posedge clk) begin
    if (block_we_i) begin
      blk_buf[block_offset_i] <= block_wr_data_i;
    end
    if (blk_start) begin
      work_buf <= blk_buf;
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      busy_q         <= 1'b0;
      word_cnt_q     <= '0;
      digest_q       <= '0;
      digest_valid_q <= 1'b0;
    end else begin
      digest_valid_q <= 1'b0;
      if (blk_start) begin
        busy_q     <= 1'b1;
        word_cnt_q <= '0;
        // A next block chains from the digest of the previous block
        if (init_i) begin
          digest_q <= FOLD_IV;
        end
      end else if (busy_q) begin
        digest_q   <= fold_sum;
        word_cnt_q <= word_cnt_q + 1'b1;
        if (last_word) begin
          busy_q         <= 1'b0;
          digest_valid_q <= last_i;
        end
      end
    end
  end

  assign ready_o        = ~busy_q;
  assign digest_valid_o = digest_valid_q;
  assign digest_o       = digest_q;

endmodule

// File: source/hash_result.sv
// Digest holding register and done flag

`timescale 1ns/1ps

module hash_result
  import pv_hash_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_b,
  input  logic                 start_i,
  input  logic                 digest_valid_i,
  input  logic [PV_DATA_W-1:0] digest_i,
  output logic [PV_DATA_W-1:0] digest_o,
  output logic                 done_o
);

  // The digest stays stable until the next run completes
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      digest_o <= '0;
      done_o   <= 1'b0;
    end else if (digest_valid_i) begin
      digest_o <= digest_i;
      done_o   <= 1'b1;
    end else if (start_i) begin
      done_o <= 1'b0;
    end
  end

endmodule

// File: source/pv_hash_top.sv
// Top level of the PCR hash generator
// Connects the PCR store, the sequencer, the fold core and the result register

`timescale 1ns/1ps

module pv_hash_top
  import pv_hash_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_b,

  input  logic                           pcr_we_i,
  input  logic [PV_ENTRY_ADDR_W-1:0]     pcr_wr_entry_i,
  input  logic [PV_ENTRY_SIZE_WIDTH-1:0] pcr_wr_offset_i,
  input  logic [PV_DATA_W-1:0]           pcr_wr_data_i,

  input  logic                           start_i,
  input  logic [PV_SIZE_OF_NONCE-1:0]    nonce_i,

  output logic                           busy_o,
  output logic                           done_o,
  output logic [PV_DATA_W-1:0]           digest_o
);

  logic [PV_ENTRY_ADDR_W-1:0]     rd_entry;
  logic [PV_ENTRY_SIZE_WIDTH-1:0] rd_offset;
  logic [PV_DATA_W-1:0]           rd_data;

  logic                           core_init;
  logic                           core_next;
  logic                           core_last;
  logic                           core_ready;
  logic                           core_digest_valid;
  logic [PV_DATA_W-1:0]           core_digest;

  logic                           block_we;
  logic [BLOCK_OFFSET_W-1:0]      block_offset;
  logic [PV_DATA_W-1:0]           block_wr_data;

  pcr_store u_pcr_store (
    .clk         (clk),
    .rst_b       (rst_b),
    .we_i        (pcr_we_i),
    .wr_entry_i  (pcr_wr_entry_i),
    .wr_offset_i (pcr_wr_offset_i),
    .wr_data_i   (pcr_wr_data_i),
    .rd_entry_i  (rd_entry),
    .rd_offset_i (rd_offset),
    .rd_data_o   (rd_data)
  );

  // Decode picks which word goes into which buffer slot
  pv_gen_hash u_gen_hash (
    .clk                 (clk),
    .rst_b               (rst_b),
    .start_i             (start_i),
    .core_ready_i        (core_ready),
    .core_digest_valid_i (core_digest_valid),
    .nonce_i             (nonce_i),
    .rd_data_i           (rd_data),
    .gen_hash_ip_o       (busy_o),
    .init_o              (core_init),
    .next_o              (core_next),
    .last_o              (core_last),
    .block_we_o          (block_we),
    .block_offset_o      (block_offset),
    .block_wr_data_o     (block_wr_data),
    .rd_entry_o          (rd_entry),
    .rd_offset_o         (rd_offset)
  );

  // Execute
  block_fold_core u_fold_core (
    .clk             (clk),
    .rst_b           (rst_b),
    .block_we_i      (block_we),
    .block_offset_i  (block_offset),
    .block_wr_data_i (block_wr_data),
    .init_i          (core_init),
    .next_i          (core_next),
    .last_i          (core_last),
    .ready_o         (core_ready),
    .digest_valid_o  (core_digest_valid),
    .digest_o        (core_digest)
  );

  // Result
  hash_result u_result (
    .clk            (clk),
    .rst_b          (rst_b),
    .start_i        (start_i),
    .digest_valid_i (core_digest_valid),
    .digest_i       (core_digest),
    .digest_o       (digest_o),
    .done_o         (done_o)
  );

endmodule

// File: test/pv_hash_tb_tasks.svh
// Reference fold model, drive tasks, compare tasks and directed tests
// All tasks start and end on a falling clock edge

  function automatic logic [PV_DATA_W-1:0] fold_word(input logic [PV_DATA_W-1:0] acc,
                                                     input logic [PV_DATA_W-1:0] word);
    return ((acc << FOLD_ROT) | (acc >> (PV_DATA_W - FOLD_ROT))) + word;
  endfunction

  // Builds both message blocks from the PCR mirror and the nonce, then folds them
  task automatic model_digest(input logic [PV_DATA_W-1:0] nonce_v,
                              output logic [PV_DATA_W-1:0] exp);
    logic [PV_DATA_W-1:0]   blk [BLOCK_NO];
    logic [4*PV_DATA_W-1:0] msg_bits;
    logic [PV_DATA_W-1:0]   acc;
    acc = FOLD_IV;
    for (int i = 0; i < BLOCK_NO; i++) begin
      blk[i] = pcr_model[i / PV_NUM_DWORDS][i % PV_NUM_DWORDS];
      acc = fold_word(acc, blk[i]);
    end
    // 32 PCR dwords and one nonce dword
    msg_bits = 128'((PV_NUM_PCR * PV_NUM_DWORDS + 1) * PV_DATA_W);
    blk[0] = nonce_v;
    blk[1] = 32'h8000_0000;
    for (int i = 2; i < BLOCK_NO - 4; i++) begin
      blk[i] = '0;
    end
    for (int k = 0; k < 4; k++) begin
      blk[BLOCK_NO - 4 + k] = msg_bits[(3 - k) * PV_DATA_W +: PV_DATA_W];
    end
    for (int i = 0; i < BLOCK_NO; i++) begin
      acc = fold_word(acc, blk[i]);
    end
    exp = acc;
  endtask

  task automatic write_pcr(input int entry, input int offset,
                           input logic [PV_DATA_W-1:0] value);
    pcr_we        = 1'b1;
    pcr_wr_entry  = PV_ENTRY_ADDR_W'(entry);
    pcr_wr_offset = PV_ENTRY_SIZE_WIDTH'(offset);
    pcr_wr_data   = value;
    pcr_model[entry][offset] = value;
    @(negedge clk);
    pcr_we = 1'b0;
  endtask

  // Waits for the sequencer to be idle so that the pulse is not dropped
  task automatic pulse_start(input logic [PV_DATA_W-1:0] nonce_v);
    while (busy) @(negedge clk);
    nonce = nonce_v;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_done(input string name);
    int waited;
    waited = 0;
    while (!done && waited < RUN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!done) begin
      $display("%s: done_o did not rise within %0d cycles of start", name, RUN_LIMIT);
      err_cnt++;
    end
  endtask

  task automatic check_digest(input string name, input logic [PV_DATA_W-1:0] exp,
                              input logic [PV_DATA_W-1:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %0b, actual %0b", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic run_and_check(input string name, input logic [PV_DATA_W-1:0] nonce_v);
    logic [PV_DATA_W-1:0] exp;
    model_digest(nonce_v, exp);
    pulse_start(nonce_v);
    wait_done(name);
    check_flag({name, " done"}, 1'b1, done);
    check_digest(name, exp, digest);
  endtask

  task automatic after_reset();
    check_flag("reset busy", 1'b0, busy);
    check_flag("reset done", 1'b0, done);
    check_digest("reset digest", '0, digest);
  endtask

  task automatic known_pcr_run();
    for (int e = 0; e < PV_NUM_PCR; e++) begin
      for (int d = 0; d < PV_NUM_DWORDS; d++) begin
        write_pcr(e, d, PV_DATA_W'(e * 16 + d));
      end
    end
    run_and_check("known pcrs", 32'h0000_1234);
  endtask

  task automatic random_pcr_runs();
    for (int r = 0; r < 3; r++) begin
      for (int e = 0; e < PV_NUM_PCR; e++) begin
        for (int d = 0; d < PV_NUM_DWORDS; d++) begin
          write_pcr(e, d, $urandom);
        end
      end
      run_and_check($sformatf("random run %0d", r), $urandom);
    end
  endtask

  task automatic start_while_busy();
    logic [PV_DATA_W-1:0] exp;
    logic [PV_DATA_W-1:0] nonce_v;
    int                   waited;
    nonce_v = $urandom;
    model_digest(nonce_v, exp);
    pulse_start(nonce_v);
    check_flag("busy after start", 1'b1, busy);
    // Second start lands in the middle of the first block
    repeat (10) @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    waited = 0;
    while (!done && waited < RUN_LIMIT) begin
      check_flag("busy during run", 1'b1, busy);
      @(negedge clk);
      waited++;
    end
    wait_done("start while busy");
    check_digest("start while busy", exp, digest);
    // The done state lasts one cycle before idle
    @(negedge clk);
    check_flag("busy after done", 1'b0, busy);
  endtask

  task automatic back_to_back_runs();
    logic [PV_DATA_W-1:0] first;
    logic [PV_DATA_W-1:0] exp;
    logic [PV_DATA_W-1:0] nonce_v;
    nonce_v = $urandom;
    run_and_check("back to back first", nonce_v);
    first = digest;
    write_pcr(5, 2, ~pcr_model[5][2]);
    check_flag("done held between runs", 1'b1, done);
    model_digest(nonce_v, exp);
    pulse_start(nonce_v);
    check_flag("done cleared by start", 1'b0, done);
    wait_done("back to back second");
    check_digest("back to back second", exp, digest);
    if (digest === first) begin
      $display("Rewriting PCR entry 5 dword 2 left the digest unchanged");
      err_cnt++;
    end
  endtask

// File: test/pv_hash_tb.sv
// Testbench top for the PCR hash generator
// Clock, reset, DUT instance, watchdog and the directed test sequence

`timescale 1ns/1ps

module pv_hash_tb
  import pv_hash_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  // Longest start to done latency of one run
  localparam int RUN_LIMIT    = 120;
  // Seven runs, four full PCR loads and reset come to about 1000 cycles
  localparam int TIMEOUT_CYCLES = 2000;

  logic                           clk;
  logic                           rst_b;
  logic                           pcr_we;
  logic [PV_ENTRY_ADDR_W-1:0]     pcr_wr_entry;
  logic [PV_ENTRY_SIZE_WIDTH-1:0] pcr_wr_offset;
  logic [PV_DATA_W-1:0]           pcr_wr_data;
  logic                           start;
  logic [PV_SIZE_OF_NONCE-1:0]    nonce;
  logic                           busy;
  logic                           done;
  logic [PV_DATA_W-1:0]           digest;

  int err_cnt   = 0;
  int cycle_cnt = 0;

  // Mirror of the PCR store contents as written by the testbench
  logic [PV_DATA_W-1:0] pcr_model [PV_NUM_PCR][PV_NUM_DWORDS];

  pv_hash_top dut0 (
    .clk             (clk),
    .rst_b           (rst_b),
    .pcr_we_i        (pcr_we),
    .pcr_wr_entry_i  (pcr_wr_entry),
    .pcr_wr_offset_i (pcr_wr_offset),
    .pcr_wr_data_i   (pcr_wr_data),
    .start_i         (start),
    .nonce_i         (nonce),
    .busy_o          (busy),
    .done_o          (done),
    .digest_o        (digest)
  );

  `include "pv_hash_tb_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors: %0d", err_cnt);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    void'($urandom(65));
    rst_b         = 1'b0;
    pcr_we        = 1'b0;
    pcr_wr_entry  = '0;
    pcr_wr_offset = '0;
    pcr_wr_data   = '0;
    start         = 1'b0;
    nonce         = '0;
    // The store comes out of reset all zero
    for (int e = 0; e < PV_NUM_PCR; e++) begin
      for (int d = 0; d < PV_NUM_DWORDS; d++) begin
        pcr_model[e][d] = '0;
      end
    end

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_b = 1'b1;
    @(negedge clk);

    after_reset();
    known_pcr_run();
    random_pcr_runs();
    start_while_busy();
    back_to_back_runs();

    repeat (2) @(negedge clk);
    $display("Errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+test
source/pv_hash_pkg.sv
source/pcr_store.sv
source/pv_gen_hash.sv
source/block_fold_core.sv
source/hash_result.sv
source/pv_hash_top.sv
test/pv_hash_tb.sv

// File: run.sh
#!/bin/sh
# Builds the PCR hash generator testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f list.f \
  --top-module pv_hash_tb \
  -o pv_hash_sim

./obj_dir/pv_hash_sim | tee sim.log

if grep -q "Finished with no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
